// File: mem_pkg.sv
`default_nettype none

// Word, line and address-field constants shared by the line memory.
package mem_pkg;

  // One bank word.
  localparam int WORD_W = 32;

  // Words in a line, which is also the number of banks in a group.
  localparam int WORDS_PER_LINE = 4;

  localparam int LINE_W = WORD_W * WORDS_PER_LINE;

  // Requester and memory-controller byte addresses.
  localparam int ADDR_W = 32;

  // Lowest bit of the word address inside a byte address.
  localparam int WADDR_LSB = 2;

  // Lowest bit of the bank-group field inside a byte address.
  localparam int GROUP_LSB = 16;

endpackage

`default_nettype wire

// File: word_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Single-port word bank. The read port returns the old contents of the
// addressed row when the same edge writes it.
module word_ram #(
  parameter int ROW_W = 10
) (
  input  logic                       clk,
  input  logic                       we,
  input  logic [ROW_W-1:0]           addr,
  input  logic [mem_pkg::WORD_W-1:0] data,
  output logic [mem_pkg::WORD_W-1:0] q
);

  import mem_pkg::*;

  logic [WORD_W-1:0] mem [2**ROW_W];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= data;
    end
    q <= mem[addr];
  end

endmodule

`default_nettype wire

// File: request_router.sv
`timescale 1ns/1ps
`default_nettype none

module request_router #(
  parameter int NUM_PORTS  = 4,
  parameter int NUM_GROUPS = 8,
  parameter int ROW_W      = 10
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                re_rt     [NUM_PORTS],
  input  logic                                we_rt     [NUM_PORTS],
  input  logic [mem_pkg::ADDR_W-1:0]          addr_rt   [NUM_PORTS],
  input  logic [mem_pkg::LINE_W-1:0]          wdata_rt  [NUM_PORTS],
  input  logic                                re_mc,
  input  logic [mem_pkg::ADDR_W-1:0]          addr_mc,
  output logic                                grp_wr    [NUM_GROUPS],
  output logic                                grp_rd    [NUM_GROUPS],
  output logic [ROW_W+1:0]                    grp_waddr [NUM_GROUPS],
  output logic [mem_pkg::LINE_W-1:0]          grp_wdata [NUM_GROUPS],
  output logic                                gnt_rt    [NUM_PORTS],
  output logic [$clog2(NUM_GROUPS)-1:0]       sel_rt    [NUM_PORTS],
  output logic                                rd_mc,
  output logic [$clog2(NUM_GROUPS)-1:0]       sel_mc
);

  import mem_pkg::*;

  localparam int GRP_W  = $clog2(NUM_GROUPS);
  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
  localparam int WA_W   = ROW_W + 2;

  logic             req      [NUM_PORTS];
  logic [GRP_W-1:0] port_grp [NUM_PORTS];
  logic             gnt_next [NUM_PORTS];

  logic              win_vld [NUM_GROUPS];
  logic [PORT_W-1:0] win_idx [NUM_GROUPS];

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    assign req[p]      = re_rt[p] | we_rt[p];
    assign port_grp[p] = addr_rt[p][GROUP_LSB +: GRP_W];

    // A port wins when it is the one its group picked and the memory
    // controller does not own the array this cycle.
    assign gnt_next[p] = req[p] && !re_mc && (win_idx[port_grp[p]] == PORT_W'(p));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        gnt_rt[p] <= 1'b0;
        sel_rt[p] <= '0;
      end else begin
        gnt_rt[p] <= gnt_next[p];
        sel_rt[p] <= port_grp[p];
      end
    end
  end

  // Fixed priority per group. Scanning downward leaves the lowest port.
  always_comb begin
    for (int g = 0; g < NUM_GROUPS; g++) begin
      win_vld[g] = 1'b0;
      win_idx[g] = '0;
      for (int p = NUM_PORTS - 1; p >= 0; p--) begin
        if (req[p] && (port_grp[p] == GRP_W'(g))) begin
          win_vld[g] = 1'b1;
          win_idx[g] = PORT_W'(p);
        end
      end
    end
  end

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        grp_wr[g] <= 1'b0;
        grp_rd[g] <= 1'b0;
      end else if (re_mc) begin
        grp_wr[g] <= 1'b0;
        grp_rd[g] <= 1'b1;
      end else begin
        grp_wr[g] <= win_vld[g] && we_rt[win_idx[g]];
        grp_rd[g] <= win_vld[g] && re_rt[win_idx[g]];
      end
    end

    always_ff @(posedge clk) begin
      if (re_mc) begin
        grp_waddr[g] <= addr_mc[WADDR_LSB +: WA_W];
      end else begin
        grp_waddr[g] <= addr_rt[win_idx[g]][WADDR_LSB +: WA_W];
      end
      grp_wdata[g] <= wdata_rt[win_idx[g]];
    end

    // Relies on the requesters never strobing read and write together.
    a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
      !(grp_wr[g] && grp_rd[g]));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_mc  <= 1'b0;
      sel_mc <= '0;
    end else begin
      rd_mc  <= re_mc;
      sel_mc <= addr_mc[GROUP_LSB +: GRP_W];
    end
  end

endmodule

`default_nettype wire

// File: bank_group.sv
`timescale 1ns/1ps
`default_nettype none

module bank_group #(
  parameter int ROW_W = 10
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr,
  input  logic                       rd,
  input  logic [ROW_W+1:0]           waddr,
  input  logic [mem_pkg::LINE_W-1:0] wdata,
  output logic [mem_pkg::LINE_W-1:0] rdata
);

  import mem_pkg::*;

  localparam int OFF_W = $clog2(WORDS_PER_LINE);

  logic [ROW_W-1:0]  bank_row  [WORDS_PER_LINE];
  logic [WORD_W-1:0] bank_word [WORDS_PER_LINE];

  logic [ROW_W-1:0]  row_q  [WORDS_PER_LINE];
  logic [WORD_W-1:0] word_q [WORDS_PER_LINE];
  logic              we_q;
  logic [OFF_W-1:0]  rot_q;
  logic [OFF_W-1:0]  rot_q2;

  logic [WORD_W-1:0] ram_q [WORDS_PER_LINE];

  // Bank b receives the line word j that satisfies (waddr + j) mod 4 == b.
  // Words past the end of the starting row carry into the next row.
  for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_in
    logic [OFF_W-1:0] j;
    logic [ROW_W+1:0] wa;

    assign j            = OFF_W'(b) - waddr[OFF_W-1:0];
    assign wa           = waddr + {{ROW_W{1'b0}}, j};
    assign bank_row[b]  = wa[ROW_W+1:OFF_W];
    assign bank_word[b] = wdata[j*WORD_W +: WORD_W];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else begin
      we_q <= wr;
    end
  end

  // Rows and words only move when the group is actually accessed.
  always_ff @(posedge clk) begin
    if (wr || rd) begin
      for (int b = 0; b < WORDS_PER_LINE; b++) begin
        row_q[b]  <= bank_row[b];
        word_q[b] <= bank_word[b];
      end
      rot_q <= waddr[OFF_W-1:0];
    end
    rot_q2 <= rot_q;
  end

  for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
    word_ram #(
      .ROW_W (ROW_W)
    ) u_ram (
      .clk  (clk),
      .we   (we_q),
      .addr (row_q[b]),
      .data (word_q[b]),
      .q    (ram_q[b])
    );
  end

  // Undo the rotation so word 0 of the line lands in the low bits again.
  for (genvar j = 0; j < WORDS_PER_LINE; j++) begin : g_out
    logic [OFF_W-1:0] b_sel;

    assign b_sel                       = rot_q2 + OFF_W'(j);
    assign rdata[j*WORD_W +: WORD_W]   = ram_q[b_sel];
  end

  a_wr_rd: assert property (@(posedge clk) disable iff (!rst_n) !(wr && rd));

endmodule

`default_nettype wire

// File: read_collector.sv
`timescale 1ns/1ps
`default_nettype none

module read_collector #(
  parameter int NUM_PORTS  = 4,
  parameter int NUM_GROUPS = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          gnt_rt    [NUM_PORTS],
  input  logic [$clog2(NUM_GROUPS)-1:0] sel_rt    [NUM_PORTS],
  input  logic                          rd_mc,
  input  logic [$clog2(NUM_GROUPS)-1:0] sel_mc,
  input  logic [mem_pkg::LINE_W-1:0]    grp_rdata [NUM_GROUPS],
  output logic [mem_pkg::LINE_W-1:0]    rdata_rt  [NUM_PORTS],
  output logic                          rdy_rt    [NUM_PORTS],
  output logic [mem_pkg::LINE_W-1:0]    rdata_mc,
  output logic                          rdy_mc
);

  localparam int GRP_W = $clog2(NUM_GROUPS);

  logic             gnt_d1 [NUM_PORTS];
  logic [GRP_W-1:0] sel_d1 [NUM_PORTS];
  logic [GRP_W-1:0] sel_d2 [NUM_PORTS];
  logic             mc_d1;
  logic [GRP_W-1:0] sel_mc_d1;
  logic [GRP_W-1:0] sel_mc_d2;
  logic [NUM_PORTS-1:0] rdy_vec;

  // Two stages line the grant up with the RAM output of the same request.
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        gnt_d1[p] <= 1'b0;
        rdy_rt[p] <= 1'b0;
        sel_d1[p] <= '0;
        sel_d2[p] <= '0;
      end else begin
        gnt_d1[p] <= gnt_rt[p];
        rdy_rt[p] <= gnt_d1[p];
        sel_d1[p] <= sel_rt[p];
        sel_d2[p] <= sel_d1[p];
      end
    end

    assign rdata_rt[p] = grp_rdata[sel_d2[p]];
    assign rdy_vec[p]  = rdy_rt[p];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mc_d1     <= 1'b0;
      rdy_mc    <= 1'b0;
      sel_mc_d1 <= '0;
      sel_mc_d2 <= '0;
    end else begin
      mc_d1     <= rd_mc;
      rdy_mc    <= mc_d1;
      sel_mc_d1 <= sel_mc;
      sel_mc_d2 <= sel_mc_d1;
    end
  end

  assign rdata_mc = grp_rdata[sel_mc_d2];

  // The router drops every requester while the memory controller reads.
  a_mc_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(rdy_mc && (|rdy_vec)));

endmodule

`default_nettype wire

// File: mem_main.sv
`timescale 1ns/1ps
`default_nettype none

module mem_main #(
  parameter int NUM_PORTS  = 4,
  parameter int NUM_GROUPS = 8,
  parameter int ROW_W      = 10
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       re_rt    [NUM_PORTS],
  input  logic                       we_rt    [NUM_PORTS],
  input  logic [mem_pkg::ADDR_W-1:0] addr_rt  [NUM_PORTS],
  input  logic [mem_pkg::LINE_W-1:0] wdata_rt [NUM_PORTS],
  input  logic                       re_mc,
  input  logic [mem_pkg::ADDR_W-1:0] addr_mc,
  output logic [mem_pkg::LINE_W-1:0] rdata_rt [NUM_PORTS],
  output logic                       rdy_rt   [NUM_PORTS],
  output logic [mem_pkg::LINE_W-1:0] rdata_mc,
  output logic                       rdy_mc
);

  import mem_pkg::*;

  localparam int GRP_W = $clog2(NUM_GROUPS);

  logic              grp_wr    [NUM_GROUPS];
  logic              grp_rd    [NUM_GROUPS];
  logic [ROW_W+1:0]  grp_waddr [NUM_GROUPS];
  logic [LINE_W-1:0] grp_wdata [NUM_GROUPS];
  logic [LINE_W-1:0] grp_rdata [NUM_GROUPS];

  logic             gnt_rt [NUM_PORTS];
  logic [GRP_W-1:0] sel_rt [NUM_PORTS];
  logic             rd_mc;
  logic [GRP_W-1:0] sel_mc;

  request_router #(
    .NUM_PORTS  (NUM_PORTS),
    .NUM_GROUPS (NUM_GROUPS),
    .ROW_W      (ROW_W)
  ) u_router (
    .clk       (clk),
    .rst_n     (rst_n),
    .re_rt     (re_rt),
    .we_rt     (we_rt),
    .addr_rt   (addr_rt),
    .wdata_rt  (wdata_rt),
    .re_mc     (re_mc),
    .addr_mc   (addr_mc),
    .grp_wr    (grp_wr),
    .grp_rd    (grp_rd),
    .grp_waddr (grp_waddr),
    .grp_wdata (grp_wdata),
    .gnt_rt    (gnt_rt),
    .sel_rt    (sel_rt),
    .rd_mc     (rd_mc),
    .sel_mc    (sel_mc)
  );

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
    bank_group #(
      .ROW_W (ROW_W)
    ) u_group (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (grp_wr[g]),
      .rd    (grp_rd[g]),
      .waddr (grp_waddr[g]),
      .wdata (grp_wdata[g]),
      .rdata (grp_rdata[g])
    );
  end

  read_collector #(
    .NUM_PORTS  (NUM_PORTS),
    .NUM_GROUPS (NUM_GROUPS)
  ) u_collector (
    .clk       (clk),
    .rst_n     (rst_n),
    .gnt_rt    (gnt_rt),
    .sel_rt    (sel_rt),
    .rd_mc     (rd_mc),
    .sel_mc    (sel_mc),
    .grp_rdata (grp_rdata),
    .rdata_rt  (rdata_rt),
    .rdy_rt    (rdy_rt),
    .rdata_mc  (rdata_mc),
    .rdy_mc    (rdy_mc)
  );

endmodule

`default_nettype wire

// File: tb_mem_main.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_main;

  import mem_pkg::*;

  localparam int NUM_PORTS      = 4;
  localparam int NUM_GROUPS     = 8;
  localparam int ROW_W          = 10;
  localparam int GRP_W          = $clog2(NUM_GROUPS);
  localparam int WA_DEPTH       = 2 ** (ROW_W + 2);
  localparam int TIMEOUT_CYCLES = 400;

  logic              clk;
  logic              rst_n;
  logic              re_rt    [NUM_PORTS];
  logic              we_rt    [NUM_PORTS];
  logic [ADDR_W-1:0] addr_rt  [NUM_PORTS];
  logic [LINE_W-1:0] wdata_rt [NUM_PORTS];
  logic              re_mc;
  logic [ADDR_W-1:0] addr_mc;
  logic [LINE_W-1:0] rdata_rt [NUM_PORTS];
  logic              rdy_rt   [NUM_PORTS];
  logic [LINE_W-1:0] rdata_mc;
  logic              rdy_mc;

  // Reference words per group and word address, with a flag for words written so far.
  logic [WORD_W-1:0] model [NUM_GROUPS][WA_DEPTH];
  bit                known [NUM_GROUPS][WA_DEPTH];

  // Expected responses, one slot per issue cycle, checked three cycles later.
  logic              exp_rdy     [4][NUM_PORTS];
  logic              exp_rd      [4][NUM_PORTS];
  logic [LINE_W-1:0] exp_data    [4][NUM_PORTS];
  logic [3:0]        exp_mask    [4][NUM_PORTS];
  logic              exp_mc_rdy  [4];
  logic [LINE_W-1:0] exp_mc_data [4];
  logic [3:0]        exp_mc_mask [4];

  int cyc;
  int cycle_count;
  int checks;
  int errors;

  mem_main #(
    .NUM_PORTS  (NUM_PORTS),
    .NUM_GROUPS (NUM_GROUPS),
    .ROW_W      (ROW_W)
  ) dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .re_rt    (re_rt),
    .we_rt    (we_rt),
    .addr_rt  (addr_rt),
    .wdata_rt (wdata_rt),
    .re_mc    (re_mc),
    .addr_mc  (addr_mc),
    .rdata_rt (rdata_rt),
    .rdy_rt   (rdy_rt),
    .rdata_mc (rdata_mc),
    .rdy_mc   (rdy_mc)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic int grp_of(input logic [ADDR_W-1:0] addr);
    return int'(addr[GROUP_LSB +: GRP_W]);
  endfunction

  function automatic int wad_of(input logic [ADDR_W-1:0] addr);
    return int'(addr[WADDR_LSB +: ROW_W + 2]);
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(input int g, input int w);
    return ADDR_W'((g << GROUP_LSB) | (w << WADDR_LSB));
  endfunction

  function automatic logic [LINE_W-1:0] rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Word j of a line lives at word address w + j, wrapping inside the group.
  task automatic read_model(input int g, input int w, output logic [LINE_W-1:0] line,
                            output logic [3:0] mask);
    int a;
    for (int j = 0; j < WORDS_PER_LINE; j++) begin
      a = (w + j) % WA_DEPTH;
      line[j*WORD_W +: WORD_W] = model[g][a];
      mask[j] = known[g][a];
    end
  endtask

  task automatic write_model(input int g, input int w, input logic [LINE_W-1:0] line);
    int a;
    for (int j = 0; j < WORDS_PER_LINE; j++) begin
      a = (w + j) % WA_DEPTH;
      model[g][a] = line[j*WORD_W +: WORD_W];
      known[g][a] = 1'b1;
    end
  endtask

  // The memory controller takes the cycle; otherwise the lowest port wins each group.
  task automatic predict();
    int  s;
    int  g;
    bit  taken [NUM_GROUPS];
    s = cyc % 4;
    for (int i = 0; i < NUM_GROUPS; i++) begin
      taken[i] = 1'b0;
    end
    exp_mc_rdy[s] = re_mc;
    if (re_mc) begin
      read_model(grp_of(addr_mc), wad_of(addr_mc), exp_mc_data[s], exp_mc_mask[s]);
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_rdy[s][p] = 1'b0;
      exp_rd[s][p]  = 1'b0;
      g = grp_of(addr_rt[p]);
      if (!re_mc && (re_rt[p] || we_rt[p]) && !taken[g]) begin
        taken[g]      = 1'b1;
        exp_rdy[s][p] = 1'b1;
        if (re_rt[p]) begin
          exp_rd[s][p] = 1'b1;
          read_model(g, wad_of(addr_rt[p]), exp_data[s][p], exp_mask[s][p]);
        end else begin
          write_model(g, wad_of(addr_rt[p]), wdata_rt[p]);
        end
      end
    end
  endtask

  task automatic compare_line(input string name, input logic [LINE_W-1:0] got,
                              input logic [LINE_W-1:0] exp, input logic [3:0] mask);
    for (int j = 0; j < WORDS_PER_LINE; j++) begin
      if (mask[j]) begin
        checks++;
        assert (got[j*WORD_W +: WORD_W] === exp[j*WORD_W +: WORD_W]) else begin
          errors++;
          $display("Error at time %0t: %s word %0d is %h, expected %h", $time, name, j,
                   got[j*WORD_W +: WORD_W], exp[j*WORD_W +: WORD_W]);
        end
      end
    end
  endtask

  task automatic check_slot(input int s);
    for (int p = 0; p < NUM_PORTS; p++) begin
      checks++;
      assert (rdy_rt[p] === exp_rdy[s][p]) else begin
        errors++;
        $display("Error at time %0t: rdy_rt[%0d] is %b, expected %b", $time, p,
                 rdy_rt[p], exp_rdy[s][p]);
      end
      if (exp_rdy[s][p] && exp_rd[s][p]) begin
        compare_line($sformatf("rdata_rt[%0d]", p), rdata_rt[p], exp_data[s][p],
                     exp_mask[s][p]);
      end
    end
    checks++;
    assert (rdy_mc === exp_mc_rdy[s]) else begin
      errors++;
      $display("Error at time %0t: rdy_mc is %b, expected %b", $time, rdy_mc, exp_mc_rdy[s]);
    end
    if (exp_mc_rdy[s]) begin
      compare_line("rdata_mc", rdata_mc, exp_mc_data[s], exp_mc_mask[s]);
    end
  endtask

  // Called just after a falling edge with the inputs of this cycle in place.
  task automatic step();
    predict();
    @(posedge clk);
    @(negedge clk);
    cyc++;
    check_slot((cyc + 1) % 4);
  endtask

  task automatic clear_inputs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      re_rt[p]    = 1'b0;
      we_rt[p]    = 1'b0;
      addr_rt[p]  = '0;
      wdata_rt[p] = '0;
    end
    re_mc   = 1'b0;
    addr_mc = '0;
  endtask

  task automatic run_idle(input int n);
    clear_inputs();
    repeat (n) step();
  endtask

  task automatic drive_read(input int p, input int g, input int w);
    re_rt[p]   = 1'b1;
    addr_rt[p] = make_addr(g, w);
  endtask

  task automatic drive_write(input int p, input int g, input int w,
                             input logic [LINE_W-1:0] d);
    we_rt[p]    = 1'b1;
    addr_rt[p]  = make_addr(g, w);
    wdata_rt[p] = d;
  endtask

  task automatic test_idle_after_reset();
    run_idle(6);
  endtask

  task automatic test_aligned_line();
    drive_write(0, 2, 'h40, rand_line());
    step();
    clear_inputs();
    drive_read(0, 2, 'h40);
    step();
    run_idle(4);
  endtask

  // Offset 3 puts word 0 in bank 3 of row 8 and words 1 to 3 in row 9.
  task automatic test_unaligned_line();
    drive_write(1, 5, 'h23, rand_line());
    step();
    clear_inputs();
    drive_read(1, 5, 'h23);
    step();
    drive_read(1, 5, 'h24);
    step();
    run_idle(4);
  endtask

  task automatic test_port_conflict();
    drive_write(0, 4, 'h10, rand_line());
    drive_write(2, 6, 'h30, rand_line());
    step();
    clear_inputs();
    drive_read(1, 4, 'h10);
    drive_read(3, 4, 'h11);
    drive_read(2, 6, 'h30);
    step();
    run_idle(4);
  endtask

  task automatic test_mc_override();
    drive_write(0, 1, 'h50, rand_line());
    drive_write(1, 3, 'h50, rand_line());
    step();
    clear_inputs();
    re_mc   = 1'b1;
    addr_mc = make_addr(1, 'h50);
    drive_write(0, 1, 'h50, rand_line());
    drive_write(1, 3, 'h50, rand_line());
    step();
    clear_inputs();
    drive_read(0, 1, 'h50);
    drive_read(1, 3, 'h50);
    step();
    run_idle(4);
  endtask

  task automatic test_random_traffic();
    int op;
    repeat (60) begin
      clear_inputs();
      for (int p = 0; p < NUM_PORTS; p++) begin
        op = int'($urandom % 4);
        if (op == 1 || op == 3) begin
          drive_read(p, int'($urandom % NUM_GROUPS), int'($urandom % 16));
        end else if (op == 2) begin
          drive_write(p, int'($urandom % NUM_GROUPS), int'($urandom % 16), rand_line());
        end
      end
      if ($urandom % 10 == 0) begin
        re_mc   = 1'b1;
        addr_mc = make_addr(int'($urandom % NUM_GROUPS), int'($urandom % 16));
      end
      step();
    end
    run_idle(4);
  endtask

  initial begin
    void'($urandom(32'h12062de0));
    clk         = 1'b0;
    rst_n       = 1'b0;
    cyc         = 0;
    cycle_count = 0;
    checks      = 0;
    errors      = 0;
    clear_inputs();
    for (int s = 0; s < 4; s++) begin
      exp_mc_rdy[s] = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        exp_rdy[s][p] = 1'b0;
        exp_rd[s][p]  = 1'b0;
      end
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    test_idle_after_reset();
    test_aligned_line();
    test_unaligned_line();
    test_port_conflict();
    test_mc_override();
    test_random_traffic();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
mem_pkg.sv
word_ram.sv
request_router.sv
bank_group.sv
read_collector.sv
mem_main.sv
tb_mem_main.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the line memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_mem_main -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
  exit 0
fi
exit 1
